//--- rtl/subcarrier_pkg.sv
// shared widths, address map and register layout for the subcarrier I/O glue
// the select word layout assumes NUM_DAC is 3
package subcarrier_pkg;

  // ******************************
  // widths
  // ******************************
  localparam int DAC_W   = 14;
  localparam int DEMOD_W = 18;
  localparam int NUM_DAC = 3;
  localparam int ADDR_W  = 12;

  typedef logic [DAC_W-1:0] dac_word_t;

  // DAC source codes, demod2 is not fitted and reads zero
  typedef enum logic [1:0] {
    SRC_EXT    = 2'd0,
    SRC_DEMOD1 = 2'd1,
    SRC_DEMOD2 = 2'd2,
    SRC_ZERO   = 2'd3
  } dac_src_t;

  // symbol bundle bit positions
  localparam int SYM_I  = 0;
  localparam int SYM_Q  = 1;
  localparam int SYM_EN = 2;
  localparam int SYM_2X = 3;

  // ******************************
  // address map
  // ******************************
  // region on addr[11:4], word offset on addr[3:2], half on addr[1]
  localparam logic [7:0] REGION_TOP  = 8'h80;
  localparam logic [1:0] OFS_RESET   = 2'd0;
  localparam logic [1:0] OFS_VERSION = 2'd1;
  localparam logic [1:0] OFS_DAC_SEL = 2'd2;
  localparam logic [1:0] OFS_DEC_SEL = 2'd3;

  localparam logic [15:0] VER_NUMBER = 16'h014E;

  // counter must be wide enough for the pulse length
  localparam int                   RST_CNT_W   = 3;
  localparam logic [RST_CNT_W-1:0] RST_STRETCH = 3'd6;

  // select word, seen by the bus as two halves
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } sel_raw_t;

  // same word as the datapath decodes it
  typedef struct packed {
    logic [14:0]              rsvd_hi;
    logic                     dec_in_sel;
    logic [9:0]               rsvd_lo;
    logic [NUM_DAC-1:0][1:0]  dac_src;
  } sel_fields_t;

  typedef union packed {
    sel_raw_t    raw;
    sel_fields_t f;
  } sel_word_u;

endpackage

//--- rtl/bus_regs.sv
// strobes are sampled on ck933, writes land on the edge that sees cs and wr low
// 32-bit registers are reached 16 bits at a time, addr[1] picks the half
module bus_regs (
  input  logic                              ck933,
  input  logic                              rs,
  input  logic                              cs_n_i,
  input  logic                              rd_n_i,
  input  logic                              wr_n_i,
  input  logic [subcarrier_pkg::ADDR_W-1:0] addr_i,
  input  logic [15:0]                       data_i,
  output logic [15:0]                       data_o,
  output logic                              data_oe_o,
  output subcarrier_pkg::sel_word_u         sel_o,
  output logic                              soft_rst_o
);

  logic                      top_hit;
  logic [1:0]                ofs;
  logic                      upper;
  logic                      wr_en;
  logic                      rst_hit;
  logic                      rst_hit_q;
  subcarrier_pkg::sel_word_u sel_q;
  subcarrier_pkg::sel_raw_t  rd_word;

  // ******************************
  // address decode
  // ******************************
  assign top_hit = (addr_i[subcarrier_pkg::ADDR_W-1:4] == subcarrier_pkg::REGION_TOP);
  assign ofs     = addr_i[3:2];
  assign upper   = addr_i[1];
  assign wr_en   = !cs_n_i && !wr_n_i && top_hit;

  // any access to the reset word counts, read or write
  assign rst_hit = !cs_n_i && top_hit && (ofs == subcarrier_pkg::OFS_RESET);

  // ******************************
  // select registers
  // ******************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      sel_q <= '0;
    end else if (wr_en) begin
      // DAC sources live in the low half
      if (ofs == subcarrier_pkg::OFS_DAC_SEL && !upper) begin
        sel_q.f.dac_src <= data_i[5:0];
      end
      // decoder input select is bit 16, reached through the high half
      if (ofs == subcarrier_pkg::OFS_DEC_SEL && upper) begin
        sel_q.f.dec_in_sel <= data_i[0];
      end
    end
  end

  assign sel_o = sel_q;

  // one pulse per access, even if cs is held low for several cycles
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      rst_hit_q <= 1'b0;
    end else begin
      rst_hit_q <= rst_hit;
    end
  end

  assign soft_rst_o = rst_hit && !rst_hit_q;

  // ******************************
  // read mux
  // ******************************
  always_comb begin
    rd_word = '0;
    if (top_hit) begin
      case (ofs)
        subcarrier_pkg::OFS_VERSION: begin
          rd_word.hi = subcarrier_pkg::VER_NUMBER;
        end
        subcarrier_pkg::OFS_DAC_SEL,
        subcarrier_pkg::OFS_DEC_SEL: begin
          rd_word = sel_q.raw;
        end
        default: begin
          rd_word = '0;
        end
      endcase
    end
  end

  assign data_o    = upper ? rd_word.hi : rd_word.lo;
  assign data_oe_o = !cs_n_i && !rd_n_i;

endmodule

//--- rtl/reset_stretch.sv
// turns the one-cycle soft reset strobe into a DAC reset of RST_STRETCH cycles
// a strobe during an active pulse restarts the count
module reset_stretch (
  input  logic ck933,
  input  logic rs,
  input  logic soft_rst_i,
  output logic dac_rst_o
);

  logic                                 strobe_q;
  logic [subcarrier_pkg::RST_CNT_W-1:0] count_q;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      strobe_q <= 1'b0;
      count_q  <= '0;
    end else begin
      strobe_q <= soft_rst_i;
      if (strobe_q) begin
        count_q <= subcarrier_pkg::RST_STRETCH;
      end else if (count_q != '0) begin
        count_q <= count_q - {{(subcarrier_pkg::RST_CNT_W-1){1'b0}}, 1'b1};
      end
    end
  end

  // high while the counter runs down
  assign dac_rst_o = (count_q != '0);

endmodule

//--- rtl/input_reclock.sv
// one register stage on every external and demodulator input
// demod taps keep only their top DAC_W bits
module input_reclock (
  input  logic                                                ck933,
  input  logic                                                rs,
  input  subcarrier_pkg::dac_word_t                           ext_dac0_data_i,
  input  subcarrier_pkg::dac_word_t                           ext_dac1_data_i,
  input  subcarrier_pkg::dac_word_t                           ext_dac2_data_i,
  input  logic [subcarrier_pkg::DEMOD_W-1:0]                  demod_dac0_data_i,
  input  logic [subcarrier_pkg::DEMOD_W-1:0]                  demod_dac1_data_i,
  input  logic [subcarrier_pkg::DEMOD_W-1:0]                  demod_dac2_data_i,
  input  logic                                                ext_i_i,
  input  logic                                                ext_q_i,
  input  logic                                                ext_sym_en_i,
  input  logic                                                ext_sym2x_en_i,
  input  logic                                                demod_i_i,
  input  logic                                                demod_q_i,
  input  logic                                                demod_sym_en_i,
  input  logic                                                demod_sym2x_en_i,
  output subcarrier_pkg::dac_word_t [subcarrier_pkg::NUM_DAC-1:0] ext_dac_o,
  output subcarrier_pkg::dac_word_t [subcarrier_pkg::NUM_DAC-1:0] demod_dac_o,
  output logic [3:0]                                          ext_sym_o,
  output logic [3:0]                                          demod_sym_o
);

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      ext_dac_o   <= '0;
      demod_dac_o <= '0;
      ext_sym_o   <= '0;
      demod_sym_o <= '0;
    end else begin
      ext_dac_o[0] <= ext_dac0_data_i;
      ext_dac_o[1] <= ext_dac1_data_i;
      ext_dac_o[2] <= ext_dac2_data_i;

      // drop the demod LSBs
      demod_dac_o[0] <= demod_dac0_data_i[subcarrier_pkg::DEMOD_W-1 -: subcarrier_pkg::DAC_W];
      demod_dac_o[1] <= demod_dac1_data_i[subcarrier_pkg::DEMOD_W-1 -: subcarrier_pkg::DAC_W];
      demod_dac_o[2] <= demod_dac2_data_i[subcarrier_pkg::DEMOD_W-1 -: subcarrier_pkg::DAC_W];

      ext_sym_o[subcarrier_pkg::SYM_I]  <= ext_i_i;
      ext_sym_o[subcarrier_pkg::SYM_Q]  <= ext_q_i;
      ext_sym_o[subcarrier_pkg::SYM_EN] <= ext_sym_en_i;
      ext_sym_o[subcarrier_pkg::SYM_2X] <= ext_sym2x_en_i;

      demod_sym_o[subcarrier_pkg::SYM_I]  <= demod_i_i;
      demod_sym_o[subcarrier_pkg::SYM_Q]  <= demod_q_i;
      demod_sym_o[subcarrier_pkg::SYM_EN] <= demod_sym_en_i;
      demod_sym_o[subcarrier_pkg::SYM_2X] <= demod_sym2x_en_i;
    end
  end

endmodule

//--- rtl/dac_channel.sv
// two cycles from inputs to pins: source mux register, then output register
// inputs are two's complement, the DAC pins take offset binary
module dac_channel (
  input  logic                      ck933,
  input  logic                      rs,
  input  subcarrier_pkg::dac_src_t  src_i,
  input  subcarrier_pkg::dac_word_t ext_i,
  input  subcarrier_pkg::dac_word_t demod_i,
  output subcarrier_pkg::dac_word_t dac_d_o
);

  subcarrier_pkg::dac_word_t mux_q;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      mux_q   <= '0;
      dac_d_o <= '0;
    end else begin
      case (src_i)
        subcarrier_pkg::SRC_EXT:    mux_q <= ext_i;
        subcarrier_pkg::SRC_DEMOD1: mux_q <= demod_i;
        // second demodulator not fitted
        subcarrier_pkg::SRC_DEMOD2: mux_q <= '0;
        subcarrier_pkg::SRC_ZERO:   mux_q <= '0;
        default:                    mux_q <= '0;
      endcase

      // flip sign bit for offset binary
      dac_d_o <= {~mux_q[subcarrier_pkg::DAC_W-1], mux_q[subcarrier_pkg::DAC_W-2:0]};
    end
  end

endmodule

//--- rtl/symbol_select.sv
// picks the decoder symbol stream, one register stage
// both streams are expected already reclocked into ck933
module symbol_select (
  input  logic       ck933,
  input  logic       rs,
  input  logic       dec_in_sel_i,
  input  logic [3:0] ext_sym_i,
  input  logic [3:0] demod_sym_i,
  output logic       sym_i_o,
  output logic       sym_q_o,
  output logic       sym_en_o,
  output logic       sym2x_en_o
);

  logic [3:0] sym_q;

  // set selects the demodulator, clear selects the external pins
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      sym_q <= '0;
    end else if (dec_in_sel_i) begin
      sym_q <= demod_sym_i;
    end else begin
      sym_q <= ext_sym_i;
    end
  end

  assign sym_i_o    = sym_q[subcarrier_pkg::SYM_I];
  assign sym_q_o    = sym_q[subcarrier_pkg::SYM_Q];
  assign sym_en_o   = sym_q[subcarrier_pkg::SYM_EN];
  assign sym2x_en_o = sym_q[subcarrier_pkg::SYM_2X];

endmodule

//--- rtl/subcarrier_io_top.sv
// bus is sampled on ck933, all inputs are assumed synchronous to it
// DAC outputs are offset binary, symbol outputs feed the downstream decoder
module subcarrier_io_top (
  input  logic                              ck933,
  input  logic                              rs,
  input  logic                              cs_n_i,
  input  logic                              rd_n_i,
  input  logic                              wr_n_i,
  input  logic [subcarrier_pkg::ADDR_W-1:0] addr_i,
  input  logic [15:0]                       data_i,
  input  subcarrier_pkg::dac_word_t         ext_dac0_data_i,
  input  subcarrier_pkg::dac_word_t         ext_dac1_data_i,
  input  subcarrier_pkg::dac_word_t         ext_dac2_data_i,
  input  logic [subcarrier_pkg::DEMOD_W-1:0] demod_dac0_data_i,
  input  logic [subcarrier_pkg::DEMOD_W-1:0] demod_dac1_data_i,
  input  logic [subcarrier_pkg::DEMOD_W-1:0] demod_dac2_data_i,
  input  logic                              ext_i_i,
  input  logic                              ext_q_i,
  input  logic                              ext_sym_en_i,
  input  logic                              ext_sym2x_en_i,
  input  logic                              demod_i_i,
  input  logic                              demod_q_i,
  input  logic                              demod_sym_en_i,
  input  logic                              demod_sym2x_en_i,
  output logic [15:0]                       data_o,
  output logic                              data_oe_o,
  output logic                              dac_rst_o,
  output subcarrier_pkg::dac_word_t         dac0_d_o,
  output subcarrier_pkg::dac_word_t         dac1_d_o,
  output subcarrier_pkg::dac_word_t         dac2_d_o,
  output logic                              sym_i_o,
  output logic                              sym_q_o,
  output logic                              sym_en_o,
  output logic                              sym2x_en_o
);

  subcarrier_pkg::sel_word_u                                     sel;
  logic                                                          soft_rst;
  subcarrier_pkg::dac_word_t [subcarrier_pkg::NUM_DAC-1:0]       ext_dac;
  subcarrier_pkg::dac_word_t [subcarrier_pkg::NUM_DAC-1:0]       demod_dac;
  subcarrier_pkg::dac_word_t [subcarrier_pkg::NUM_DAC-1:0]       dac_d;
  logic [3:0]                                                    ext_sym;
  logic [3:0]                                                    demod_sym;

  // ******************************
  // processor side
  // ******************************
  bus_regs u_bus_regs (
    .ck933      (ck933),
    .rs         (rs),
    .cs_n_i     (cs_n_i),
    .rd_n_i     (rd_n_i),
    .wr_n_i     (wr_n_i),
    .addr_i     (addr_i),
    .data_i     (data_i),
    .data_o     (data_o),
    .data_oe_o  (data_oe_o),
    .sel_o      (sel),
    .soft_rst_o (soft_rst)
  );

  reset_stretch u_reset_stretch (
    .ck933      (ck933),
    .rs         (rs),
    .soft_rst_i (soft_rst),
    .dac_rst_o  (dac_rst_o)
  );

  // ******************************
  // datapath
  // ******************************
  input_reclock u_input_reclock (
    .ck933             (ck933),
    .rs                (rs),
    .ext_dac0_data_i   (ext_dac0_data_i),
    .ext_dac1_data_i   (ext_dac1_data_i),
    .ext_dac2_data_i   (ext_dac2_data_i),
    .demod_dac0_data_i (demod_dac0_data_i),
    .demod_dac1_data_i (demod_dac1_data_i),
    .demod_dac2_data_i (demod_dac2_data_i),
    .ext_i_i           (ext_i_i),
    .ext_q_i           (ext_q_i),
    .ext_sym_en_i      (ext_sym_en_i),
    .ext_sym2x_en_i    (ext_sym2x_en_i),
    .demod_i_i         (demod_i_i),
    .demod_q_i         (demod_q_i),
    .demod_sym_en_i    (demod_sym_en_i),
    .demod_sym2x_en_i  (demod_sym2x_en_i),
    .ext_dac_o         (ext_dac),
    .demod_dac_o       (demod_dac),
    .ext_sym_o         (ext_sym),
    .demod_sym_o       (demod_sym)
  );

  // one channel per DAC, source code taken from the select word
  for (genvar g = 0; g < subcarrier_pkg::NUM_DAC; g++) begin : g_dac
    dac_channel u_dac_channel (
      .ck933   (ck933),
      .rs      (rs),
      .src_i   (subcarrier_pkg::dac_src_t'(sel.f.dac_src[g])),
      .ext_i   (ext_dac[g]),
      .demod_i (demod_dac[g]),
      .dac_d_o (dac_d[g])
    );
  end

  assign dac0_d_o = dac_d[0];
  assign dac1_d_o = dac_d[1];
  assign dac2_d_o = dac_d[2];

  symbol_select u_symbol_select (
    .ck933        (ck933),
    .rs           (rs),
    .dec_in_sel_i (sel.f.dec_in_sel),
    .ext_sym_i    (ext_sym),
    .demod_sym_i  (demod_sym),
    .sym_i_o      (sym_i_o),
    .sym_q_o      (sym_q_o),
    .sym_en_o     (sym_en_o),
    .sym2x_en_o   (sym2x_en_o)
  );

endmodule

//--- bench/subcarrier_tb.sv
// directed tests for the subcarrier I/O glue, outputs sampled on the falling edge
// latencies are checked cycle by cycle against the fixed pipeline depths
module subcarrier_tb;

  // all tests take about 300 cycles, so twice that is the limit
  localparam int TIMEOUT_CYCLES = 600;

  logic                                ck933;
  logic                                rs;
  logic                                cs_n;
  logic                                rd_n;
  logic                                wr_n;
  logic [subcarrier_pkg::ADDR_W-1:0]   addr;
  logic [15:0]                         wdata;
  logic [15:0]                         rdata;
  logic                                data_oe;
  logic                                dac_rst;
  subcarrier_pkg::dac_word_t           ext_dac [subcarrier_pkg::NUM_DAC];
  logic [subcarrier_pkg::DEMOD_W-1:0]  demod_dac [subcarrier_pkg::NUM_DAC];
  subcarrier_pkg::dac_word_t           dac_d [subcarrier_pkg::NUM_DAC];
  // symbol bundles: bit 0 i, bit 1 q, bit 2 sym_en, bit 3 sym2x_en
  logic [3:0]                          ext_sym;
  logic [3:0]                          demod_sym;
  logic                                sym_i;
  logic                                sym_q;
  logic                                sym_en;
  logic                                sym2x_en;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [31:0] rng_state;
  logic [5:0]  exp_dac_sel;
  logic        exp_dec_sel;

  subcarrier_io_top uut (
    .ck933 (ck933), .rs (rs), .cs_n_i (cs_n), .rd_n_i (rd_n), .wr_n_i (wr_n),
    .addr_i (addr), .data_i (wdata),
    .ext_dac0_data_i (ext_dac[0]), .ext_dac1_data_i (ext_dac[1]),
    .ext_dac2_data_i (ext_dac[2]),
    .demod_dac0_data_i (demod_dac[0]), .demod_dac1_data_i (demod_dac[1]),
    .demod_dac2_data_i (demod_dac[2]),
    .ext_i_i (ext_sym[0]), .ext_q_i (ext_sym[1]), .ext_sym_en_i (ext_sym[2]),
    .ext_sym2x_en_i (ext_sym[3]),
    .demod_i_i (demod_sym[0]), .demod_q_i (demod_sym[1]), .demod_sym_en_i (demod_sym[2]),
    .demod_sym2x_en_i (demod_sym[3]),
    .data_o (rdata), .data_oe_o (data_oe), .dac_rst_o (dac_rst),
    .dac0_d_o (dac_d[0]), .dac1_d_o (dac_d[1]), .dac2_d_o (dac_d[2]),
    .sym_i_o (sym_i), .sym_q_o (sym_q), .sym_en_o (sym_en), .sym2x_en_o (sym2x_en)
  );

  initial begin
    ck933 = 1'b0;
    forever #2 ck933 = ~ck933;
  end

  always @(posedge ck933) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles before the tests completed", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ******************************
  // helpers
  // ******************************
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [subcarrier_pkg::ADDR_W-1:0] reg_addr(input logic [1:0] ofs,
                                                                 input logic       upper);
    return {subcarrier_pkg::REGION_TOP, ofs, upper, 1'b0};
  endfunction

  // DAC pins are offset binary, so the sign bit is flipped
  function automatic subcarrier_pkg::dac_word_t expected_dac(
      input subcarrier_pkg::dac_src_t           code,
      input subcarrier_pkg::dac_word_t          ext_s,
      input logic [subcarrier_pkg::DEMOD_W-1:0] demod_s);
    subcarrier_pkg::dac_word_t v;
    case (code)
      subcarrier_pkg::SRC_EXT:    v = ext_s;
      subcarrier_pkg::SRC_DEMOD1: v = demod_s[17:4];
      default:                    return 14'h2000;
    endcase
    return v ^ 14'h2000;
  endfunction

  function automatic logic [15:0] expected_sel_half(input logic upper);
    return upper ? {15'd0, exp_dec_sel} : {10'd0, exp_dac_sel};
  endfunction

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_dac(input string name, input subcarrier_pkg::dac_word_t got,
                           input subcarrier_pkg::dac_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_symbols(input logic [3:0] exp);
    check_bit("sym_i_o", sym_i, exp[0]);
    check_bit("sym_q_o", sym_q, exp[1]);
    check_bit("sym_en_o", sym_en, exp[2]);
    check_bit("sym2x_en_o", sym2x_en, exp[3]);
  endtask

  // write lands on the second rising edge
  task automatic bus_write(input logic [subcarrier_pkg::ADDR_W-1:0] a, input logic [15:0] d);
    @(posedge ck933);
    cs_n  <= 1'b0;
    wr_n  <= 1'b0;
    addr  <= a;
    wdata <= d;
    @(negedge ck933);
    check_bit("data_oe_o", data_oe, 1'b0);
    @(posedge ck933);
    cs_n <= 1'b1;
    wr_n <= 1'b1;
  endtask

  task automatic bus_read(input logic [subcarrier_pkg::ADDR_W-1:0] a, output logic [15:0] d);
    @(posedge ck933);
    cs_n <= 1'b0;
    rd_n <= 1'b0;
    addr <= a;
    @(negedge ck933);
    check_bit("data_oe_o", data_oe, 1'b1);
    d = rdata;
    @(posedge ck933);
    cs_n <= 1'b1;
    rd_n <= 1'b1;
  endtask

  task automatic read_and_compare(input logic [subcarrier_pkg::ADDR_W-1:0] a,
                                  input logic [15:0] exp);
    logic [15:0] d;
    bus_read(a, d);
    check_word($sformatf("data_o at %h", a), d, exp);
  endtask

  // ******************************
  // directed tests
  // ******************************
  task automatic check_after_reset();
    @(negedge ck933);
    for (int g = 0; g < subcarrier_pkg::NUM_DAC; g++) begin
      check_dac($sformatf("dac%0d_d_o", g), dac_d[g], 14'h0000);
    end
    check_bit("dac_rst_o", dac_rst, 1'b0);
    check_bit("data_oe_o", data_oe, 1'b0);
    check_symbols(4'h0);
  endtask

  task automatic test_version();
    read_and_compare(reg_addr(subcarrier_pkg::OFS_VERSION, 1'b1), 16'h014E);
    read_and_compare(reg_addr(subcarrier_pkg::OFS_VERSION, 1'b0), 16'h0000);
    @(negedge ck933);
    check_bit("data_oe_o", data_oe, 1'b0);
  endtask

  task automatic test_select_regs();
    logic [31:0] r;
    for (int h = 0; h < 2; h++) begin
      read_and_compare(reg_addr(subcarrier_pkg::OFS_DAC_SEL, h[0]), 16'h0000);
      read_and_compare(reg_addr(subcarrier_pkg::OFS_DEC_SEL, h[0]), 16'h0000);
    end
    r = next_rand();
    bus_write(reg_addr(subcarrier_pkg::OFS_DAC_SEL, 1'b0), r[15:0]);
    exp_dac_sel = r[5:0];
    read_and_compare(reg_addr(subcarrier_pkg::OFS_DAC_SEL, 1'b0), expected_sel_half(1'b0));
    bus_write(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b1), 16'hFFFF);
    exp_dec_sel = 1'b1;
    read_and_compare(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b1), 16'h0001);
    // low half of the decoder word holds nothing writable
    bus_write(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b0), 16'h0000);
    read_and_compare(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b1), expected_sel_half(1'b1));
    read_and_compare(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b0), expected_sel_half(1'b0));
    read_and_compare(12'h7F8, 16'h0000);
    read_and_compare(12'hF0A, 16'h0000);
    bus_write(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b1), 16'h0000);
    exp_dec_sel = 1'b0;
  endtask

  task automatic test_dac_sources();
    logic [31:0]                        r;
    logic [5:0]                         codes;
    subcarrier_pkg::dac_word_t          ext_s [subcarrier_pkg::NUM_DAC];
    logic [subcarrier_pkg::DEMOD_W-1:0] dem_s [subcarrier_pkg::NUM_DAC];
    for (int p = 0; p < 4; p++) begin
      // each channel gets a different code, so all pairs are covered over p
      for (int g = 0; g < subcarrier_pkg::NUM_DAC; g++) begin
        codes[2*g +: 2] = 2'(p + g);
      end
      bus_write(reg_addr(subcarrier_pkg::OFS_DAC_SEL, 1'b0), {10'd0, codes});
      exp_dac_sel = codes;
      for (int k = 0; k < 2; k++) begin
        for (int g = 0; g < subcarrier_pkg::NUM_DAC; g++) begin
          r = next_rand();
          ext_s[g] = r[13:0];
          r = next_rand();
          dem_s[g] = r[17:0];
        end
        @(posedge ck933);
        for (int g = 0; g < subcarrier_pkg::NUM_DAC; g++) begin
          ext_dac[g]   <= ext_s[g];
          demod_dac[g] <= dem_s[g];
        end
        repeat (4) @(posedge ck933);
        @(negedge ck933);
        for (int g = 0; g < subcarrier_pkg::NUM_DAC; g++) begin
          check_dac($sformatf("dac%0d_d_o", g), dac_d[g],
                    expected_dac(subcarrier_pkg::dac_src_t'(codes[2*g +: 2]),
                                 ext_s[g], dem_s[g]));
        end
      end
    end
  endtask

  task automatic test_dac_latency();
    logic [31:0]               r;
    subcarrier_pkg::dac_word_t first;
    subcarrier_pkg::dac_word_t second;
    bus_write(reg_addr(subcarrier_pkg::OFS_DAC_SEL, 1'b0), 16'h0000);
    exp_dac_sel = 6'd0;
    r = next_rand();
    first  = r[13:0];
    second = r[29:16];
    @(posedge ck933);
    ext_dac[1] <= first;
    repeat (4) @(posedge ck933);
    ext_dac[1] <= second;
    // three stages: reclock, source mux, output register
    for (int k = 0; k < 4; k++) begin
      @(negedge ck933);
      check_dac($sformatf("dac1_d_o %0d cycles after change", k), dac_d[1],
                expected_dac(subcarrier_pkg::SRC_EXT, (k < 3) ? first : second, '0));
    end
  endtask

  task automatic test_symbol_select();
    logic [31:0] r;
    logic [3:0]  prev;
    logic [3:0]  chosen;
    for (int s = 0; s < 2; s++) begin
      bus_write(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b1), {15'd0, s[0]});
      exp_dec_sel = s[0];
      ext_sym   <= 4'h0;
      demod_sym <= 4'h0;
      repeat (3) @(posedge ck933);
      prev = 4'h0;
      for (int n = 0; n < 16; n++) begin
        r = next_rand();
        chosen = s[0] ? r[7:4] : r[3:0];
        @(posedge ck933);
        ext_sym   <= r[3:0];
        demod_sym <= r[7:4];
        @(negedge ck933);
        @(negedge ck933);
        check_symbols(prev);
        @(negedge ck933);
        check_symbols(chosen);
        prev = chosen;
      end
    end
  endtask

  task automatic test_soft_reset();
    logic [31:0] r;
    logic [15:0] d;
    r = next_rand();
    bus_write(reg_addr(subcarrier_pkg::OFS_DAC_SEL, 1'b0), r[15:0]);
    exp_dac_sel = r[5:0];
    bus_read(reg_addr(subcarrier_pkg::OFS_RESET, 1'b0), d);
    check_word("data_o at reset word", d, 16'h0000);
    // strobe register plus counter load, then six cycles high
    for (int k = 0; k < 8; k++) begin
      @(negedge ck933);
      check_bit($sformatf("dac_rst_o %0d cycles after access", k + 1), dac_rst,
                (k >= 1) && (k <= 6));
    end
    read_and_compare(reg_addr(subcarrier_pkg::OFS_DAC_SEL, 1'b0), expected_sel_half(1'b0));
    read_and_compare(reg_addr(subcarrier_pkg::OFS_DEC_SEL, 1'b1), expected_sel_half(1'b1));
  endtask

  // ******************************
  // main sequence
  // ******************************
  initial begin
    rng_state   = 32'haed3;
    exp_dac_sel = 6'd0;
    exp_dec_sel = 1'b0;
    rs    <= 1'b1;
    cs_n  <= 1'b1;
    rd_n  <= 1'b1;
    wr_n  <= 1'b1;
    addr  <= '0;
    wdata <= '0;
    for (int g = 0; g < subcarrier_pkg::NUM_DAC; g++) begin
      ext_dac[g]   <= '0;
      demod_dac[g] <= '0;
    end
    ext_sym   <= 4'h0;
    demod_sym <= 4'h0;
    repeat (8) @(posedge ck933);
    rs <= 1'b0;
    check_after_reset();
    test_version();
    test_select_regs();
    test_dac_sources();
    test_dac_latency();
    test_symbol_select();
    test_soft_reset();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- subcarrier_io.f
rtl/subcarrier_pkg.sv
rtl/bus_regs.sv
rtl/reset_stretch.sv
rtl/input_reclock.sv
rtl/dac_channel.sv
rtl/symbol_select.sv
rtl/subcarrier_io_top.sv
bench/subcarrier_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f subcarrier_io.f \
  --top-module subcarrier_tb \
  -o subcarrier_sim

./obj_dir/subcarrier_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation passed"
